// ==== include/vis_opf_codes.svh ====
`ifndef VIS_OPF_CODES_SVH
`define VIS_OPF_CODES_SVH

// Operation class encodings of opf[8:0]
// A ? bit is free inside the class and matched as a wildcard
localparam logic [8:0] OPF_ADD       = 9'b0_0101_0???;
localparam logic [8:0] OPF_FALIGN    = 9'b0_0100_1000;
localparam logic [8:0] OPF_LOGIC     = 9'b0_011?_????;
localparam logic [8:0] OPF_SIAM      = 9'b0_1000_0001;
// Bit 1 is the little-endian flavour
localparam logic [8:0] OPF_ALIGNADDR = 9'b0_0001_10?0;

// Logical functions, taken from opf[4:1]
localparam logic [3:0] LF_ZERO    = 4'h0;
localparam logic [3:0] LF_NOR     = 4'h1;
localparam logic [3:0] LF_ANDNOT2 = 4'h2;
localparam logic [3:0] LF_NOT2    = 4'h3;
localparam logic [3:0] LF_ANDNOT1 = 4'h4;
localparam logic [3:0] LF_NOT1    = 4'h5;
localparam logic [3:0] LF_XOR     = 4'h6;
localparam logic [3:0] LF_NAND    = 4'h7;
localparam logic [3:0] LF_AND     = 4'h8;
localparam logic [3:0] LF_XNOR    = 4'h9;
localparam logic [3:0] LF_SRC1    = 4'ha;
localparam logic [3:0] LF_ORNOT2  = 4'hb;
localparam logic [3:0] LF_SRC2    = 4'hc;
localparam logic [3:0] LF_ORNOT1  = 4'hd;
localparam logic [3:0] LF_OR      = 4'he;
localparam logic [3:0] LF_ONE     = 4'hf;

`endif

// ==== hdl/vis_ctl_pkg.sv ====
package vis_ctl_pkg;

`include "vis_opf_codes.svh"

   localparam int OPF_W           = 9;
   localparam int NUM_THREADS_DEF = 4;
   localparam int TID_W           = $clog2(NUM_THREADS_DEF);
   localparam int SRADDR_W        = 7;
   localparam int REG_W           = 5;

   // State-register address of the GSR
   localparam logic [SRADDR_W-1:0] GSR_SRADDR = 7'd19;

   // Bit 2 selects the GSR mode, bits 1:0 hold it
   typedef logic [2:0] gsr_rnd_t;
   typedef logic [2:0] gsr_align_t;
   typedef logic [1:0] fsr_rnd_t;

   typedef enum logic [2:0] {
      VIS_NONE      = 3'd0,
      VIS_ADD       = 3'd1,
      VIS_FALIGN    = 3'd2,
      VIS_LOGIC     = 3'd3,
      VIS_SIAM      = 3'd4,
      VIS_ALIGNADDR = 3'd5
   } vis_class_t;

   typedef enum logic [3:0] {
      FN_ZERO    = LF_ZERO,
      FN_NOR     = LF_NOR,
      FN_ANDNOT2 = LF_ANDNOT2,
      FN_NOT2    = LF_NOT2,
      FN_ANDNOT1 = LF_ANDNOT1,
      FN_NOT1    = LF_NOT1,
      FN_XOR     = LF_XOR,
      FN_NAND    = LF_NAND,
      FN_AND     = LF_AND,
      FN_XNOR    = LF_XNOR,
      FN_SRC1    = LF_SRC1,
      FN_ORNOT2  = LF_ORNOT2,
      FN_SRC2    = LF_SRC2,
      FN_ORNOT1  = LF_ORNOT1,
      FN_OR      = LF_OR,
      FN_ONE     = LF_ONE
   } logic_func_t;

endpackage

// ==== hdl/gsr_write_if.sv ====
interface gsr_write_if #(
   parameter int NUM_THREADS = vis_ctl_pkg::NUM_THREADS_DEF
);
   import vis_ctl_pkg::*;

   localparam int TW = $clog2(NUM_THREADS);

   // WSR path, with the M-stage data delayed to W2
   logic             wsr_we;
   logic [TW-1:0]    wsr_tid;
   gsr_rnd_t         wsr_rnd;
   gsr_align_t       wsr_align;

   // siam and alignaddr path from the media pipeline
   logic             siam_we;
   logic             alignaddr_we;
   logic             little;
   logic [TW-1:0]    op_tid;
   gsr_rnd_t         siam_rnd;

   modport wsr  (output wsr_we, wsr_tid, wsr_rnd, wsr_align);
   modport vis  (output siam_we, alignaddr_we, little, op_tid, siam_rnd);
   modport file (input  wsr_we, wsr_tid, wsr_rnd, wsr_align,
                 input  siam_we, alignaddr_we, little, op_tid, siam_rnd);

endinterface

// ==== hdl/vis_opf_decode.sv ====
module vis_opf_decode (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [vis_ctl_pkg::OPF_W-1:0]   opf,
   input  logic                            visop_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]   frs1_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]   frs2_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]   frd_e,
   output vis_ctl_pkg::vis_class_t         op_class,
   output logic                            little,
   output vis_ctl_pkg::logic_func_t        logic_func,
   output logic                            illegal_vis_e,
   output logic                            vis_nofrf_e,
   output logic                            sel_add,
   output logic                            sel_align,
   output logic                            sel_log,
   output logic                            add_cin,
   output logic                            add32,
   output logic                            add_subtract
);
   import vis_ctl_pkg::*;

   logic is_siam;
   logic is_logic;
   logic rs1_unused;
   logic rs2_unused;
   logic bad_siam;

   always_comb begin
      if (opf ==? OPF_ADD)             op_class = VIS_ADD;
      else if (opf ==? OPF_FALIGN)     op_class = VIS_FALIGN;
      else if (opf ==? OPF_LOGIC)      op_class = VIS_LOGIC;
      else if (opf ==? OPF_SIAM)       op_class = VIS_SIAM;
      else if (opf ==? OPF_ALIGNADDR)  op_class = VIS_ALIGNADDR;
      else                             op_class = VIS_NONE;
   end

   assign little     = opf[1];
   assign logic_func = logic_func_t'(opf[4:1]);
   assign is_siam    = (op_class == VIS_SIAM);
   assign is_logic   = (op_class == VIS_LOGIC);

   // Register fields that the function never reads must be zero
   assign rs1_unused = is_siam |
                       is_logic & (logic_func inside {FN_ZERO, FN_ONE, FN_SRC2, FN_NOT2});
   assign rs2_unused = is_logic & (logic_func inside {FN_ZERO, FN_ONE, FN_SRC1, FN_NOT1});
   assign bad_siam   = is_siam & ((frd_e != '0) | frs2_e[4] | frs2_e[3]);

   assign illegal_vis_e = visop_e & ((op_class == VIS_NONE) |
                                     rs1_unused & (frs1_e != '0) |
                                     rs2_unused & (frs2_e != '0) |
                                     bad_siam);

   // No register file access at all
   assign vis_nofrf_e = visop_e & (is_siam | (op_class == VIS_ALIGNADDR) |
                                   is_logic & (logic_func inside {FN_ZERO, FN_ONE}));

   // Result mux and adder controls
   assign sel_add   = (op_class == VIS_ADD);
   assign sel_align = (op_class == VIS_FALIGN);
   assign sel_log   = ~(sel_add | sel_align);
   assign add_cin   = opf[2];
   assign add32     = opf[1];

   // Subtract has a heavy fanout, so it gets a flop of its own
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) add_subtract <= 1'b0;
      else         add_subtract <= opf[2];
   end

endmodule

// ==== hdl/vis_logic_ctl.sv ====
module vis_logic_ctl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  vis_ctl_pkg::logic_func_t  logic_func,
   output logic                      log_sel_pass,
   output logic                      log_sel_nand,
   output logic                      log_sel_nor,
   output logic                      log_sel_xor,
   output logic                      log_invert_rs1,
   output logic                      log_invert_rs2,
   output logic                      log_constant,
   output logic                      log_pass_const,
   output logic                      log_pass_rs1,
   output logic                      log_pass_rs2
);
   import vis_ctl_pkg::*;

   logic pass_rs1_q;
   logic pass_rs2_q;

   ////////////////////////////////////////////////////////////
   // Function to mux select and operand inversion
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         log_sel_pass   <= 1'b0;
         log_sel_nand   <= 1'b0;
         log_sel_nor    <= 1'b0;
         log_sel_xor    <= 1'b0;
         log_invert_rs1 <= 1'b0;
         log_invert_rs2 <= 1'b0;
         log_constant   <= 1'b0;
         pass_rs1_q     <= 1'b0;
         pass_rs2_q     <= 1'b0;
      end else begin
         log_sel_pass   <= logic_func inside {FN_ZERO, FN_ONE, FN_SRC1, FN_SRC2,
                                              FN_NOT1, FN_NOT2};
         log_sel_nand   <= logic_func inside {FN_OR, FN_NAND, FN_ORNOT1, FN_ORNOT2};
         log_sel_nor    <= logic_func inside {FN_AND, FN_NOR, FN_ANDNOT1, FN_ANDNOT2};
         log_sel_xor    <= logic_func inside {FN_XOR, FN_XNOR};
         // De Morgan forms reuse the nand and nor gates
         log_invert_rs1 <= logic_func inside {FN_NOT1, FN_OR, FN_AND, FN_ORNOT2,
                                              FN_ANDNOT2};
         log_invert_rs2 <= logic_func inside {FN_NOT2, FN_OR, FN_AND, FN_ORNOT1,
                                              FN_ANDNOT1, FN_XNOR};
         log_constant   <= (logic_func == FN_ONE);
         pass_rs1_q     <= logic_func inside {FN_SRC1, FN_NOT1};
         pass_rs2_q     <= logic_func inside {FN_SRC2, FN_NOT2};
      end
   end

   // rs1 has priority on the pass path
   assign log_pass_rs1   = pass_rs1_q;
   assign log_pass_rs2   = pass_rs2_q & ~pass_rs1_q;
   assign log_pass_const = ~(log_pass_rs1 | log_pass_rs2);

endmodule

// ==== hdl/vis_pipe_track.sv ====
module vis_pipe_track (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            visop_e,
   input  vis_ctl_pkg::vis_class_t         op_class,
   input  logic                            little,
   input  logic [vis_ctl_pkg::TID_W-1:0]   tid_e,
   input  vis_ctl_pkg::gsr_rnd_t           rnd_e,
   input  logic                            kill_w,
   input  logic                            flush_w2,
   gsr_write_if.vis                        gw,
   output logic                            visop_m,
   output logic                            visop_w_vld,
   output logic                            vis_result,
   output logic                            vis_wen_next
);
   import vis_ctl_pkg::*;

   // Payload that travels with each operation
   typedef struct packed {
      vis_class_t        cls;
      logic [TID_W-1:0]  tid;
      logic              little;
      gsr_rnd_t          rnd;
   } op_t;

   op_t        op_m;
   op_t        op_w;
   op_t        op_w2;
   vis_class_t cls_w3;
   logic       visop_w;
   logic       visop_w2;
   logic       visop_w2_vld;
   logic       visop_w3;

   ////////////////////////////////////////////////////////////
   // Valid bits, E to W3
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         visop_m  <= 1'b0;
         visop_w  <= 1'b0;
         visop_w2 <= 1'b0;
         visop_w3 <= 1'b0;
      end else begin
         visop_m  <= visop_e;
         visop_w  <= visop_m;
         visop_w2 <= visop_w_vld;
         visop_w3 <= visop_w2_vld;
      end
   end

   always_ff @(posedge clk) begin
      op_m   <= '{cls: op_class, tid: tid_e, little: little, rnd: rnd_e};
      op_w   <= op_m;
      op_w2  <= op_w;
      cls_w3 <= op_w2.cls;
   end

   // Traps and replays are folded into kill_w upstream
   assign visop_w_vld  = visop_w & ~kill_w;
   assign visop_w2_vld = visop_w2 & ~flush_w2;

   // GSR updates leave at W2
   assign gw.siam_we      = visop_w2_vld & (op_w2.cls == VIS_SIAM);
   assign gw.alignaddr_we = visop_w2_vld & (op_w2.cls == VIS_ALIGNADDR);
   assign gw.little       = op_w2.little;
   assign gw.op_tid       = op_w2.tid;
   assign gw.siam_rnd     = op_w2.rnd;

   assign vis_result   = visop_w3;
   assign vis_wen_next = visop_w3 & ~(cls_w3 inside {VIS_SIAM, VIS_ALIGNADDR});

endmodule

// ==== hdl/gsr_wsr_pipe.sv ====
module gsr_wsr_pipe (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic [vis_ctl_pkg::SRADDR_W-1:0]  sraddr_d,
   input  logic                              wsr_inst_e,
   input  logic                              inst_vld_w,
   input  logic                              flush_w2,
   input  logic [vis_ctl_pkg::TID_W-1:0]     tid_e,
   input  vis_ctl_pkg::gsr_align_t           gsr_align_m,
   input  vis_ctl_pkg::gsr_rnd_t             gsr_rnd_m,
   gsr_write_if.wsr                          gw
);
   import vis_ctl_pkg::*;

   logic             gsr_addr_e;
   logic             wgsr_m;
   logic             wgsr_w;
   logic             wgsr_w2;
   logic [TID_W-1:0] tid_m;
   logic [TID_W-1:0] tid_w;
   logic [TID_W-1:0] tid_w2;
   gsr_align_t       align_w;
   gsr_align_t       align_w2;
   gsr_rnd_t         rnd_w;
   gsr_rnd_t         rnd_w2;

   // Address is decoded a cycle ahead of E
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gsr_addr_e <= 1'b0;
         wgsr_m     <= 1'b0;
         wgsr_w     <= 1'b0;
         wgsr_w2    <= 1'b0;
      end else begin
         gsr_addr_e <= (sraddr_d == GSR_SRADDR);
         wgsr_m     <= wsr_inst_e & gsr_addr_e;
         wgsr_w     <= wgsr_m;
         wgsr_w2    <= wgsr_w & inst_vld_w;
      end
   end

   always_ff @(posedge clk) begin
      tid_m    <= tid_e;
      tid_w    <= tid_m;
      tid_w2   <= tid_w;
      align_w  <= gsr_align_m;
      align_w2 <= align_w;
      rnd_w    <= gsr_rnd_m;
      rnd_w2   <= rnd_w;
   end

   assign gw.wsr_we    = wgsr_w2 & ~flush_w2;
   assign gw.wsr_tid   = tid_w2;
   assign gw.wsr_align = align_w2;
   assign gw.wsr_rnd   = rnd_w2;

endmodule

// ==== hdl/gsr_thread_file.sv ====
module gsr_thread_file #(
   parameter int NUM_THREADS = vis_ctl_pkg::NUM_THREADS_DEF
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [$clog2(NUM_THREADS)-1:0]  tid,
   input  logic [$clog2(NUM_THREADS)-1:0]  tid_e,
   input  vis_ctl_pkg::fsr_rnd_t           fsr_rnd,
   gsr_write_if.file                       gw,
   output vis_ctl_pkg::fsr_rnd_t           fpu_rnd,
   output logic                            align0,
   output logic                            align2,
   output logic                            align4,
   output logic                            align6,
   output logic                            align_odd,
   output vis_ctl_pkg::gsr_rnd_t           rsr_rnd_m,
   output vis_ctl_pkg::gsr_align_t         rsr_align_m
);
   import vis_ctl_pkg::*;

   gsr_rnd_t   rnd_q   [NUM_THREADS];
   gsr_align_t align_q [NUM_THREADS];
   gsr_align_t addr_align;
   gsr_align_t align_d1;

   // Little-endian alignaddr stores the negated offset
   assign addr_align = gw.little ? gsr_align_t'(3'd0 - gw.wsr_align) : gw.wsr_align;

   ////////////////////////////////////////////////////////////
   // Per-thread state, WSR beats siam and alignaddr
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int t = 0; t < NUM_THREADS; t++) begin
            rnd_q[t]   <= '0;
            align_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < NUM_THREADS; t++) begin
            if (gw.wsr_we && gw.wsr_tid == t) begin
               rnd_q[t]   <= gw.wsr_rnd;
               align_q[t] <= gw.wsr_align;
            end else begin
               if (gw.siam_we && gw.op_tid == t)      rnd_q[t]   <= gw.siam_rnd;
               if (gw.alignaddr_we && gw.op_tid == t) align_q[t] <= addr_align;
            end
         end
      end
   end

   // Readout for the fp thread and for rd at M
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fpu_rnd     <= '0;
         align_d1    <= '0;
         rsr_rnd_m   <= '0;
         rsr_align_m <= '0;
      end else begin
         fpu_rnd     <= rnd_q[tid][2] ? rnd_q[tid][1:0] : fsr_rnd;
         align_d1    <= align_q[tid];
         rsr_rnd_m   <= rnd_q[tid_e];
         rsr_align_m <= align_q[tid_e];
      end
   end

   // falign shifter steps of two bytes plus an odd byte
   assign align0    = (align_d1[2:1] == 2'd0);
   assign align2    = (align_d1[2:1] == 2'd1);
   assign align4    = (align_d1[2:1] == 2'd2);
   assign align6    = (align_d1[2:1] == 2'd3);
   assign align_odd = align_d1[0];

endmodule

// ==== hdl/vis_ctl_top.sv ====
module vis_ctl_top #(
   parameter int NUM_THREADS = vis_ctl_pkg::NUM_THREADS_DEF
) (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic [vis_ctl_pkg::OPF_W-1:0]     opf,
   input  logic                              visop_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]     frs1_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]     frs2_e,
   input  logic [vis_ctl_pkg::REG_W-1:0]     frd_e,
   input  logic [vis_ctl_pkg::TID_W-1:0]     tid_e,
   input  logic [vis_ctl_pkg::TID_W-1:0]     tid,
   input  vis_ctl_pkg::gsr_rnd_t             rnd_e,
   input  logic                              kill_w,
   input  logic                              flush_w2,
   input  logic [vis_ctl_pkg::SRADDR_W-1:0]  sraddr_d,
   input  logic                              wsr_inst_e,
   input  logic                              inst_vld_w,
   input  vis_ctl_pkg::gsr_align_t           gsr_align_m,
   input  vis_ctl_pkg::gsr_rnd_t             gsr_rnd_m,
   input  vis_ctl_pkg::fsr_rnd_t             fsr_rnd,
   output logic                              illegal_vis_e,
   output logic                              vis_nofrf_e,
   output logic                              sel_add,
   output logic                              sel_align,
   output logic                              sel_log,
   output logic                              add_cin,
   output logic                              add32,
   output logic                              add_subtract,
   output logic                              log_sel_pass,
   output logic                              log_sel_nand,
   output logic                              log_sel_nor,
   output logic                              log_sel_xor,
   output logic                              log_invert_rs1,
   output logic                              log_invert_rs2,
   output logic                              log_constant,
   output logic                              log_pass_const,
   output logic                              log_pass_rs1,
   output logic                              log_pass_rs2,
   output logic                              visop_m,
   output logic                              visop_w_vld,
   output logic                              vis_result,
   output logic                              vis_wen_next,
   output vis_ctl_pkg::fsr_rnd_t             fpu_rnd,
   output logic                              align0,
   output logic                              align2,
   output logic                              align4,
   output logic                              align6,
   output logic                              align_odd,
   output vis_ctl_pkg::gsr_rnd_t             rsr_rnd_m,
   output vis_ctl_pkg::gsr_align_t           rsr_align_m
);
   import vis_ctl_pkg::*;

   vis_class_t  op_class;
   logic        little;
   logic_func_t logic_func;

   gsr_write_if #(.NUM_THREADS(NUM_THREADS)) gsr_if ();

   vis_opf_decode u_decode (
      .clk, .arst_n, .opf, .visop_e, .frs1_e, .frs2_e, .frd_e,
      .op_class, .little, .logic_func, .illegal_vis_e, .vis_nofrf_e,
      .sel_add, .sel_align, .sel_log, .add_cin, .add32, .add_subtract
   );

   vis_logic_ctl u_logic (
      .clk, .arst_n, .logic_func,
      .log_sel_pass, .log_sel_nand, .log_sel_nor, .log_sel_xor,
      .log_invert_rs1, .log_invert_rs2, .log_constant,
      .log_pass_const, .log_pass_rs1, .log_pass_rs2
   );

   vis_pipe_track u_pipe (
      .clk, .arst_n, .visop_e, .op_class, .little, .tid_e, .rnd_e,
      .kill_w, .flush_w2, .gw(gsr_if.vis),
      .visop_m, .visop_w_vld, .vis_result, .vis_wen_next
   );

   gsr_wsr_pipe u_wsr (
      .clk, .arst_n, .sraddr_d, .wsr_inst_e, .inst_vld_w, .flush_w2,
      .tid_e, .gsr_align_m, .gsr_rnd_m, .gw(gsr_if.wsr)
   );

   gsr_thread_file #(.NUM_THREADS(NUM_THREADS)) u_gsr (
      .clk, .arst_n, .tid, .tid_e, .fsr_rnd, .gw(gsr_if.file),
      .fpu_rnd, .align0, .align2, .align4, .align6, .align_odd,
      .rsr_rnd_m, .rsr_align_m
   );

endmodule

// ==== tb/vis_ctl_tb.sv ====
module vis_ctl_tb;
   import vis_ctl_pkg::*;

   localparam int NUM_CYCLES  = 4000;
   localparam int DRAIN_LIMIT = 16;

   // One media operation as the model tracks it
   typedef struct packed {
      logic             vld;
      vis_class_t       cls;
      logic [TID_W-1:0] tid;
      logic             little;
      gsr_rnd_t         rnd;
   } op_rec_t;

   // One GSR write travelling down the WSR path
   typedef struct packed {
      logic             vld;
      logic [TID_W-1:0] tid;
      gsr_align_t       align;
      gsr_rnd_t         rnd;
   } wsr_rec_t;

   logic                clk;
   logic                arst_n;
   logic [OPF_W-1:0]    opf;
   logic                visop_e;
   logic [REG_W-1:0]    frs1_e;
   logic [REG_W-1:0]    frs2_e;
   logic [REG_W-1:0]    frd_e;
   logic [TID_W-1:0]    tid_e;
   logic [TID_W-1:0]    tid;
   gsr_rnd_t            rnd_e;
   logic                kill_w;
   logic                flush_w2;
   logic [SRADDR_W-1:0] sraddr_d;
   logic                wsr_inst_e;
   logic                inst_vld_w;
   gsr_align_t          gsr_align_m;
   gsr_rnd_t            gsr_rnd_m;
   fsr_rnd_t            fsr_rnd;
   logic                illegal_vis_e;
   logic                vis_nofrf_e;
   logic                sel_add;
   logic                sel_align;
   logic                sel_log;
   logic                add_cin;
   logic                add32;
   logic                add_subtract;
   logic                log_sel_pass;
   logic                log_sel_nand;
   logic                log_sel_nor;
   logic                log_sel_xor;
   logic                log_invert_rs1;
   logic                log_invert_rs2;
   logic                log_constant;
   logic                log_pass_const;
   logic                log_pass_rs1;
   logic                log_pass_rs2;
   logic                visop_m;
   logic                visop_w_vld;
   logic                vis_result;
   logic                vis_wen_next;
   fsr_rnd_t            fpu_rnd;
   logic                align0;
   logic                align2;
   logic                align4;
   logic                align6;
   logic                align_odd;
   gsr_rnd_t            rsr_rnd_m;
   gsr_align_t          rsr_align_m;

   integer seed;
   int     cycle;
   int     n_siam;
   int     n_addr;
   int     n_wsr;
   int     n_clash;
   int     n_result;

   // Reference model state
   gsr_rnd_t         m_rnd   [NUM_THREADS_DEF];
   gsr_align_t       m_align [NUM_THREADS_DEF];
   op_rec_t          ops [4];  // M, W, W2, W3
   wsr_rec_t         wr  [3];  // M, W, W2
   logic [OPF_W-1:0] prev_opf;
   logic             addr_ok;
   fsr_rnd_t         exp_fpu_rnd;
   gsr_align_t       exp_falign;
   gsr_rnd_t         exp_rsr_rnd;
   gsr_align_t       exp_rsr_align;

   vis_ctl_top #(.NUM_THREADS(NUM_THREADS_DEF)) u_dut (.*);

   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Reference decode
   ////////////////////////////////////////////////////////////
   function automatic vis_class_t classify(input logic [OPF_W-1:0] o);
      if (o[8:3] == 6'b001010)                          classify = VIS_ADD;
      else if (o == 9'h048)                             classify = VIS_FALIGN;
      else if (o[8:5] == 4'b0011)                       classify = VIS_LOGIC;
      else if (o == 9'h081)                             classify = VIS_SIAM;
      else if (o[8:2] == 7'b0000110 && o[0] == 1'b0)    classify = VIS_ALIGNADDR;
      else                                              classify = VIS_NONE;
   endfunction

   // Packed msb first as pass nand nor xor, inv1 inv2, constant pass_const pass_rs1 pass_rs2
   function automatic logic [9:0] logic_ctl_exp(input logic [3:0] lf);
      case (lf)
         LF_ZERO:    logic_ctl_exp = 10'b1000_00_0100;
         LF_NOR:     logic_ctl_exp = 10'b0010_00_0100;
         LF_ANDNOT2: logic_ctl_exp = 10'b0010_10_0100;
         LF_NOT2:    logic_ctl_exp = 10'b1000_01_0001;
         LF_ANDNOT1: logic_ctl_exp = 10'b0010_01_0100;
         LF_NOT1:    logic_ctl_exp = 10'b1000_10_0010;
         LF_XOR:     logic_ctl_exp = 10'b0001_00_0100;
         LF_NAND:    logic_ctl_exp = 10'b0100_00_0100;
         LF_AND:     logic_ctl_exp = 10'b0010_11_0100;
         LF_XNOR:    logic_ctl_exp = 10'b0001_01_0100;
         LF_SRC1:    logic_ctl_exp = 10'b1000_00_0010;
         LF_ORNOT2:  logic_ctl_exp = 10'b0100_10_0100;
         LF_SRC2:    logic_ctl_exp = 10'b1000_00_0001;
         LF_ORNOT1:  logic_ctl_exp = 10'b0100_01_0100;
         LF_OR:      logic_ctl_exp = 10'b0100_11_0100;
         default:    logic_ctl_exp = 10'b1000_00_1100;
      endcase
   endfunction

   // Classes 0 to 4 are forced, anything else is a raw random opf
   function automatic logic [OPF_W-1:0] pick_opf(input logic [2:0] sel, input logic [31:0] r);
      case (sel)
         3'd0:    pick_opf = {6'b001010, r[2:0]};
         3'd1:    pick_opf = 9'h048;
         3'd2:    pick_opf = {4'b0011, r[4:0]};
         3'd3:    pick_opf = 9'h081;
         3'd4:    pick_opf = {7'b0000110, r[0], 1'b0};
         default: pick_opf = r[8:0];
      endcase
   endfunction

   function automatic logic pipe_busy();
      pipe_busy = ops[0].vld | ops[1].vld | ops[2].vld | ops[3].vld |
                  wr[0].vld | wr[1].vld | wr[2].vld;
   endfunction

   task automatic check_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s at cycle %0d: expected 0x%0h, actual 0x%0h",
                  name, cycle, exp, act);
         $display("** FAIL **");
         $fatal(1, "Output mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus, checks and model update
   ////////////////////////////////////////////////////////////
   task automatic drive_inputs(input logic idle);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      opf         <= pick_opf(r0[2:0], r1);
      visop_e     <= ~idle & r0[3];
      // Zero register fields half of the time so legal encodings show up
      frs1_e      <= r0[4] ? '0 : r1[13:9];
      frs2_e      <= r0[5] ? '0 : r1[18:14];
      frd_e       <= r0[6] ? '0 : r1[23:19];
      tid_e       <= r0[8:7];
      tid         <= r0[10:9];
      rnd_e       <= r0[13:11];
      kill_w      <= (r0[16:14] == 3'd0);
      flush_w2    <= (r0[19:17] == 3'd0);
      sraddr_d    <= (r0[21:20] != 2'd0) ? GSR_SRADDR : r2[6:0];
      wsr_inst_e  <= ~idle & (r0[23:22] == 2'd0);
      inst_vld_w  <= (r0[26:24] != 3'd0);
      gsr_align_m <= r2[9:7];
      gsr_rnd_m   <= r2[12:10];
      fsr_rnd     <= r2[14:13];
   endtask

   task automatic check_outputs();
      vis_class_t cls;
      logic [3:0] lf;
      logic       is_logic;
      logic       is_siam;
      logic       rs1_unused;
      logic       rs2_unused;
      logic       bad_siam;
      logic       ill;
      logic       nofrf;
      cls        = classify(opf);
      lf         = opf[4:1];
      is_logic   = (cls == VIS_LOGIC);
      is_siam    = (cls == VIS_SIAM);
      rs1_unused = is_siam | is_logic & (lf inside {LF_ZERO, LF_ONE, LF_SRC2, LF_NOT2});
      rs2_unused = is_logic & (lf inside {LF_ZERO, LF_ONE, LF_SRC1, LF_NOT1});
      bad_siam   = is_siam & ((frd_e != '0) | frs2_e[4] | frs2_e[3]);
      ill        = visop_e & ((cls == VIS_NONE) | rs1_unused & (frs1_e != '0) |
                              rs2_unused & (frs2_e != '0) | bad_siam);
      nofrf      = visop_e & (is_siam | (cls == VIS_ALIGNADDR) |
                              is_logic & (lf inside {LF_ZERO, LF_ONE}));
      check_equal("illegal_vis_e", ill, illegal_vis_e);
      check_equal("vis_nofrf_e", nofrf, vis_nofrf_e);
      check_equal("sel_add", cls == VIS_ADD, sel_add);
      check_equal("sel_align", cls == VIS_FALIGN, sel_align);
      check_equal("sel_log", !(cls inside {VIS_ADD, VIS_FALIGN}), sel_log);
      check_equal("add_cin", opf[2], add_cin);
      check_equal("add32", opf[1], add32);
      check_equal("add_subtract", prev_opf[2], add_subtract);
      check_equal("logic_ctl", logic_ctl_exp(prev_opf[4:1]),
                  {log_sel_pass, log_sel_nand, log_sel_nor, log_sel_xor,
                   log_invert_rs1, log_invert_rs2, log_constant,
                   log_pass_const, log_pass_rs1, log_pass_rs2});
      check_equal("visop_m", ops[0].vld, visop_m);
      check_equal("visop_w_vld", ops[1].vld & ~kill_w, visop_w_vld);
      check_equal("vis_result", ops[3].vld, vis_result);
      check_equal("vis_wen_next",
                  ops[3].vld & !(ops[3].cls inside {VIS_SIAM, VIS_ALIGNADDR}), vis_wen_next);
      check_equal("fpu_rnd", exp_fpu_rnd, fpu_rnd);
      check_equal("align_ctl", {4'b0001 << exp_falign[2:1], exp_falign[0]},
                  {align6, align4, align2, align0, align_odd});
      check_equal("rsr_rnd_m", exp_rsr_rnd, rsr_rnd_m);
      check_equal("rsr_align_m", exp_rsr_align, rsr_align_m);
   endtask

   task automatic update_model();
      logic       wsr_we;
      logic       siam_we;
      logic       addr_we;
      gsr_align_t addr_val;
      // Readout flops see the state before this cycle's writes
      exp_fpu_rnd   = m_rnd[tid][2] ? m_rnd[tid][1:0] : fsr_rnd;
      exp_falign    = m_align[tid];
      exp_rsr_rnd   = m_rnd[tid_e];
      exp_rsr_align = m_align[tid_e];

      wsr_we   = wr[2].vld & ~flush_w2;
      siam_we  = ops[2].vld & ~flush_w2 & (ops[2].cls == VIS_SIAM);
      addr_we  = ops[2].vld & ~flush_w2 & (ops[2].cls == VIS_ALIGNADDR);
      addr_val = ops[2].little ? gsr_align_t'(8 - wr[2].align) : wr[2].align;
      if (siam_we) begin
         m_rnd[ops[2].tid] = ops[2].rnd;
         n_siam++;
      end
      if (addr_we) begin
         m_align[ops[2].tid] = addr_val;
         n_addr++;
      end
      // WSR goes last so it overrides both fields
      if (wsr_we) begin
         if ((siam_we | addr_we) && ops[2].tid == wr[2].tid)
            n_clash++;
         m_rnd[wr[2].tid]   = wr[2].rnd;
         m_align[wr[2].tid] = wr[2].align;
         n_wsr++;
      end
      if (ops[3].vld)
         n_result++;

      ops[3]     = ops[2];
      ops[3].vld = ops[2].vld & ~flush_w2;
      ops[2]     = ops[1];
      ops[2].vld = ops[1].vld & ~kill_w;
      ops[1]     = ops[0];
      ops[0]     = '{vld: visop_e, cls: classify(opf), tid: tid_e,
                     little: opf[1], rnd: rnd_e};

      // M data moves with every WSR slot, valid or not
      wr[2]       = wr[1];
      wr[2].vld   = wr[1].vld & inst_vld_w;
      wr[1]       = wr[0];
      wr[1].align = gsr_align_m;
      wr[1].rnd   = gsr_rnd_m;
      wr[0]       = '{vld: wsr_inst_e & addr_ok, tid: tid_e, align: '0, rnd: '0};
      addr_ok     = (sraddr_d == GSR_SRADDR);
      prev_opf    = opf;
   endtask

   task automatic step_cycle(input logic idle);
      @(posedge clk);
      drive_inputs(idle);
      @(negedge clk);
      check_outputs();
      update_model();
      cycle++;
   endtask

   task automatic drain_pipe();
      int waited;
      waited = 0;
      while (pipe_busy()) begin
         if (waited >= DRAIN_LIMIT) begin
            $display("Timeout: operations still in flight after %0d idle cycles", waited);
            $display("** FAIL **");
            $fatal(1, "Drain timeout");
         end
         step_cycle(1'b1);
         waited++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      seed        = 73147;
      cycle       = 0;
      n_siam      = 0;
      n_addr      = 0;
      n_wsr       = 0;
      n_clash     = 0;
      n_result    = 0;
      clk         = 1'b0;
      arst_n      = 1'b0;
      opf         = '0;
      visop_e     = 1'b0;
      frs1_e      = '0;
      frs2_e      = '0;
      frd_e       = '0;
      tid_e       = '0;
      tid         = '0;
      rnd_e       = '0;
      kill_w      = 1'b0;
      flush_w2    = 1'b0;
      sraddr_d    = '0;
      wsr_inst_e  = 1'b0;
      inst_vld_w  = 1'b0;
      gsr_align_m = '0;
      gsr_rnd_m   = '0;
      fsr_rnd     = '0;
      for (int t = 0; t < NUM_THREADS_DEF; t++) begin
         m_rnd[t]   = '0;
         m_align[t] = '0;
      end
      for (int s = 0; s < 4; s++)
         ops[s] = '0;
      for (int s = 0; s < 3; s++)
         wr[s] = '0;
      prev_opf      = '0;
      addr_ok       = 1'b0;
      exp_fpu_rnd   = '0;
      exp_falign    = '0;
      exp_rsr_rnd   = '0;
      exp_rsr_align = '0;

      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      repeat (NUM_CYCLES) step_cycle(1'b0);
      drain_pipe();

      if (n_siam == 0 || n_addr == 0 || n_wsr == 0 || n_clash == 0 || n_result == 0) begin
         $display("Coverage hole: siam %0d, alignaddr %0d, wsr %0d, clash %0d, result %0d",
                  n_siam, n_addr, n_wsr, n_clash, n_result);
         $display("** FAIL **");
         $fatal(1, "Stimulus missed a scenario");
      end else begin
         $display("%0d cycles: siam %0d, alignaddr %0d, wsr %0d, clash %0d, result %0d",
                  cycle, n_siam, n_addr, n_wsr, n_clash, n_result);
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// ==== src.f ====
+incdir+include
hdl/vis_ctl_pkg.sv
hdl/gsr_write_if.sv
hdl/vis_opf_decode.sv
hdl/vis_logic_ctl.sv
hdl/vis_pipe_track.sv
hdl/gsr_wsr_pipe.sv
hdl/gsr_thread_file.sv
hdl/vis_ctl_top.sv
tb/vis_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: vis_ctl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vis_ctl_pkg.sv
      - hdl/gsr_write_if.sv
      - hdl/vis_opf_decode.sv
      - hdl/vis_logic_ctl.sv
      - hdl/vis_pipe_track.sv
      - hdl/gsr_wsr_pipe.sv
      - hdl/gsr_thread_file.sv
      - hdl/vis_ctl_top.sv
  - target: test
    files:
      - tb/vis_ctl_tb.sv
